//--- coherent_mem_sys.f
verilog/coherence_pkg.sv
verilog/ram_model.sv
verilog/snoop_responder.sv
verilog/memory_control.sv
verilog/coherent_mem_sys.sv
tests/coherent_mem_sys_chk.sv
tests/coherent_mem_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the coherent memory regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module coherent_mem_sys_tb \
   -f coherent_mem_sys.f \
   -Mdir obj_dir -o coherent_mem_sys_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/coherent_mem_sys_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi
exit 0

//--- tests/coherent_mem_sys_chk.sv
// coherent_mem_sys_chk
// concurrent assertions on the memory controller FSM and its ports
// attached to every memory_control instance by bind
`timescale 1ns/1ps
`default_nettype none

module coherent_mem_sys_chk (
   input logic                                                CLK,
   input logic                                                nRST,
   input coherence_pkg::mc_state_t                            state,
   input coherence_pkg::ram_req_t                             ram_req,
   input coherence_pkg::core_rsp_t [coherence_pkg::NCORES-1:0] core_rsp,
   input logic                     [coherence_pkg::NCORES-1:0] wb_done
);

   logic in_cache;
   assign in_cache = (state == coherence_pkg::CACHE0) || (state == coherence_pkg::CACHE1);

   ram_cmd_excl: assert property (@(posedge CLK) disable iff (!nRST)
      !(ram_req.ren && ram_req.wen))
      else $error("ram read and write requested together");

   // only one data port completes per cycle
   one_dwait_low: assert property (@(posedge CLK) disable iff (!nRST)
      core_rsp[0].dwait || core_rsp[1].dwait)
      else $error("both data ports released in the same cycle");

   snoop0_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
      state == coherence_pkg::SNOOP0 |=> state != coherence_pkg::SNOOP0)
      else $error("SNOOP0 held longer than one cycle");

   snoop1_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
      state == coherence_pkg::SNOOP1 |=> state != coherence_pkg::SNOOP1)
      else $error("SNOOP1 held longer than one cycle");

   wb_done_in_cache: assert property (@(posedge CLK) disable iff (!nRST)
      (|wb_done) |-> in_cache)
      else $error("write-back done outside a cache-to-cache transfer");

endmodule

bind memory_control coherent_mem_sys_chk chk (
   .CLK(CLK), .nRST(nRST), .state(state), .ram_req(ram_req),
   .core_rsp(core_rsp), .wb_done(wb_done)
);

`default_nettype wire

//--- tests/coherent_mem_sys_tb.sv
// coherent_mem_sys_tb
// file-driven testbench for the dual-core memory subsystem
// shadow RAM plus per-core modified lines predict every returned word
`timescale 1ns/1ps
`default_nettype none

module coherent_mem_sys_tb;

   localparam int    TIMEOUT   = 50;   // cycles allowed per wait
   localparam string DATA_FILE = "tests/coherent_mem_sys_testdata.txt";

   logic                                                 CLK = 1'b0;
   logic                                                 nRST;
   coherence_pkg::core_req_t [coherence_pkg::NCORES-1:0] core_req;
   coherence_pkg::core_rsp_t [coherence_pkg::NCORES-1:0] core_rsp;

   coherence_pkg::word_t shadow_ram [coherence_pkg::RAM_WORDS];
   coherence_pkg::word_t mod_data   [2][coherence_pkg::RAM_WORDS];   // dirty copy per core
   logic                 mod_valid  [2][coherence_pkg::RAM_WORDS];
   int unsigned          lcg_state = 88188;

   always #50 CLK = ~CLK;   // 100 ns period

   coherent_mem_sys dut (.CLK(CLK), .nRST(nRST), .core_req(core_req), .core_rsp(core_rsp));

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic int word_of(input coherence_pkg::addr_t a);
      return int'(a[9:2]);   // byte offset dropped
   endfunction

   // a dirty copy in the other core wins and is written back
   function automatic coherence_pkg::word_t predict_read(input int core,
                                                         input coherence_pkg::addr_t a);
      int w;
      int other;
      w     = word_of(a);
      other = 1 - core;
      if (mod_valid[other][w]) begin
         shadow_ram[w]       = mod_data[other][w];
         mod_valid[other][w] = 1'b0;   // other copy now shared
      end
      return shadow_ram[w];
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "run stopped on error");
   endtask

   task automatic check_value(input string name, input coherence_pkg::word_t actual,
                              input coherence_pkg::word_t expected);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
         $display("Regression failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // sample mid-cycle until the port's wait drops
   task automatic wait_released(input int core, input bit instr);
      int cycles;
      bit low;
      cycles = 0;
      low    = 1'b0;
      while (!low) begin
         @(negedge CLK);
         low = instr ? !core_rsp[core].iwait : !core_rsp[core].dwait;
         cycles++;
         if (!low && cycles >= TIMEOUT)
            abort_run($sformatf("timeout: core %0d never got its %s response", core,
                                instr ? "fetch" : "data"));
      end
   endtask

   task automatic fetch_instr(input int core, input coherence_pkg::addr_t a,
                              input coherence_pkg::word_t file_exp);
      coherence_pkg::word_t exp;
      exp = shadow_ram[word_of(a)];   // fetches bypass snooping
      check_value("testdata expect", file_exp, exp);
      core_req[core].iren  = 1'b1;
      core_req[core].iaddr = a;
      wait_released(core, 1'b1);
      check_value($sformatf("core%0d iload", core), core_rsp[core].iload, exp);
      core_req[core].iren = 1'b0;
   endtask

   task automatic read_word(input int core, input coherence_pkg::addr_t a,
                            input coherence_pkg::word_t file_exp);
      coherence_pkg::word_t exp;
      exp = predict_read(core, a);
      check_value("testdata expect", file_exp, exp);
      core_req[core].dren  = 1'b1;
      core_req[core].daddr = a;
      wait_released(core, 1'b0);
      check_value($sformatf("core%0d dload", core), core_rsp[core].dload, exp);
      core_req[core].dren = 1'b0;
   endtask

   task automatic write_word(input int core, input coherence_pkg::addr_t a,
                             input coherence_pkg::word_t d);
      core_req[core].dwen   = 1'b1;
      core_req[core].daddr  = a;
      core_req[core].dstore = d;
      wait_released(core, 1'b0);
      core_req[core].dwen     = 1'b0;
      shadow_ram[word_of(a)] = d;
   endtask

   // store hit in own cache as a one-cycle strobe
   task automatic store_modified(input int core, input coherence_pkg::addr_t a,
                                 input coherence_pkg::word_t d);
      core_req[core].mod_wr = 1'b1;
      core_req[core].daddr  = a;
      core_req[core].dstore = d;
      @(negedge CLK);
      core_req[core].mod_wr          = 1'b0;
      mod_valid[core][word_of(a)] = 1'b1;
      mod_data[core][word_of(a)]  = d;
   endtask

   // both cores at once with core 0 expected to finish first
   task automatic issue_pair(input bit instr, input coherence_pkg::addr_t a0,
                             input coherence_pkg::addr_t a1, input coherence_pkg::word_t e0,
                             input coherence_pkg::word_t e1);
      coherence_pkg::addr_t a   [2];
      coherence_pkg::word_t exp [2];
      bit                   done [2];
      int                   cycles;
      int                   first;
      a[0]   = a0;
      a[1]   = a1;
      first  = -1;
      cycles = 0;
      for (int c = 0; c < 2; c++) begin
         exp[c]  = instr ? shadow_ram[word_of(a[c])] : predict_read(c, a[c]);
         done[c] = 1'b0;
         if (instr) begin
            core_req[c].iren  = 1'b1;
            core_req[c].iaddr = a[c];
         end else begin
            core_req[c].dren  = 1'b1;
            core_req[c].daddr = a[c];
         end
      end
      check_value("testdata expect", e0, exp[0]);
      check_value("testdata expect", e1, exp[1]);
      while (!(done[0] && done[1])) begin
         @(negedge CLK);
         cycles++;
         for (int c = 0; c < 2; c++) begin
            if (!done[c] && !(instr ? core_rsp[c].iwait : core_rsp[c].dwait)) begin
               check_value($sformatf("core%0d %s", c, instr ? "iload" : "dload"),
                           instr ? core_rsp[c].iload : core_rsp[c].dload, exp[c]);
               if (instr)
                  core_req[c].iren = 1'b0;
               else
                  core_req[c].dren = 1'b0;
               done[c] = 1'b1;
               if (first < 0)
                  first = c;
            end
         end
         if (!(done[0] && done[1]) && cycles >= TIMEOUT)
            abort_run("timeout: simultaneous requests did not both complete");
      end
      check_value("first completing core", 32'(first), 32'd0);
   endtask

   initial begin
      int                   fd;
      int                   n;
      int                   core;
      int                   cmds;
      string                op;
      string                rest;
      coherence_pkg::addr_t addr;
      coherence_pkg::addr_t held_addr;
      coherence_pkg::word_t data;
      coherence_pkg::word_t exp_w;
      coherence_pkg::word_t held_exp;
      core_req  = '0;
      nRST      = 1'b0;
      cmds      = 0;
      held_addr = '0;
      held_exp  = '0;
      for (int i = 0; i < coherence_pkg::RAM_WORDS; i++) begin
         shadow_ram[i]   = '0;   // RAM model starts cleared
         mod_valid[0][i] = 1'b0;
         mod_valid[1][i] = 1'b0;
         mod_data[0][i]  = '0;
         mod_data[1][i]  = '0;
      end
      repeat (5) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      @(negedge CLK);
      for (int c = 0; c < 2; c++) begin   // idle ports hold their waits
         check_value($sformatf("core%0d iwait", c), 32'(core_rsp[c].iwait), 32'd1);
         check_value($sformatf("core%0d dwait", c), 32'(core_rsp[c].dwait), 32'd1);
      end

      fd = $fopen(DATA_FILE, "r");
      if (fd == 0)
         abort_run("cannot open the stimulus file");
      n = $fscanf(fd, "%s", op);
      while (n == 1) begin
         if (op == "#") begin
            n = $fgets(rest, fd);   // rest of a comment line
         end else begin
            n = $fscanf(fd, "%d %h %h %h", core, addr, data, exp_w);
            if (n != 4 || core < 0 || core > 1)
               abort_run({"malformed stimulus line for operation ", op});
            repeat ((lcg_next() >> 16) % 4) @(negedge CLK);   // 0..3 idle cycles
            case (op)
               "IFETCH": fetch_instr(core, addr, exp_w);
               "READ":   read_word(core, addr, exp_w);
               "WRITE":  write_word(core, addr, data);
               "MODWR":  store_modified(core, addr, data);
               "BOTH": begin
                  if (core == 0) begin   // held until the core 1 half arrives
                     held_addr = addr;
                     held_exp  = exp_w;
                  end else begin
                     issue_pair(data[0] == 1'b0, held_addr, addr, held_exp, exp_w);
                  end
               end
               default: abort_run({"unknown operation in stimulus file: ", op});
            endcase
            cmds++;
         end
         n = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
      if (cmds == 0) begin
         abort_run("no commands found in the stimulus file");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- tests/coherent_mem_sys_testdata.txt
# op core addr data expect : core decimal, the rest hex, text after # ignored
# READ/IFETCH ignore data, WRITE/MODWR ignore expect, BOTH pairs use data 0 fetch 1 read
READ   0 0040 00000000 00000000   # unwritten word
IFETCH 1 0044 00000000 00000000
WRITE  0 0100 cafe0001 00000000
READ   0 0100 00000000 cafe0001
WRITE  1 0104 cafe0002 00000000
READ   1 0104 00000000 cafe0002
READ   0 0104 00000000 cafe0002
READ   1 0100 00000000 cafe0001
MODWR  1 0200 d1d1d1d1 00000000
READ   0 0200 00000000 d1d1d1d1   # cache to cache
READ   1 0200 00000000 d1d1d1d1   # written back, now from RAM
MODWR  1 0300 beef0300 00000000
MODWR  1 0304 beef0304 00000000
WRITE  0 0308 12345678 00000000   # neighbour of dirty lines
READ   0 0308 00000000 12345678
READ   0 0100 00000000 cafe0001
READ   0 0304 00000000 beef0304
IFETCH 0 0304 00000000 beef0304
IFETCH 0 0300 00000000 00000000   # fetch sees stale RAM
WRITE  0 0380 aaaa0380 00000000
WRITE  1 0384 bbbb0384 00000000
BOTH   0 0380 00000000 aaaa0380
BOTH   1 0384 00000000 bbbb0384
BOTH   0 0384 00000001 bbbb0384
BOTH   1 0380 00000001 aaaa0380
MODWR  0 0280 c0c00280 00000000
READ   1 0280 00000000 c0c00280   # core 0 dirty line
READ   0 0280 00000000 c0c00280
READ   0 0300 00000000 beef0300

//--- verilog/coherence_pkg.sv
// coherence_pkg
// shared types and constants for the dual-core snooping memory subsystem
// covers core, snoop and RAM request/response bundles plus the FSM encodings
`default_nettype none

package coherence_pkg;

   localparam int NCORES      = 2;    // two cores built into the controller FSM
   localparam int RAM_WORDS   = 256;
   localparam int RAM_LATENCY = 2;    // request seen to ACCESS, in cycles
   localparam int MOD_ENTRIES = 4;    // modified lines per snoop responder

   localparam int WORD_LSB  = 2;      // byte offset bits, ignored
   localparam int WORD_BITS = $clog2(RAM_WORDS);
   localparam int LAT_BITS  = $clog2(RAM_LATENCY + 1);
   localparam int ENT_BITS  = $clog2(MOD_ENTRIES);

   typedef logic [31:0]          word_t;
   typedef logic [15:0]          addr_t;
   typedef logic [WORD_BITS-1:0] word_idx_t;   // RAM word select, addr[9:2]
   typedef logic [LAT_BITS-1:0]  lat_cnt_t;
   typedef logic [ENT_BITS-1:0]  ent_idx_t;

   // ACCESS is the completing cycle of a read or write
   typedef enum logic [1:0] {FREE, BUSY, ACCESS} ram_state_t;

   typedef enum logic [2:0] {
      IDLE, SNOOP0, SNOOP1, CACHE0, CACHE1, MEM0, MEM1
   } mc_state_t;

   typedef struct packed {
      logic  iren;
      addr_t iaddr;
      logic  dren;
      logic  dwen;
      addr_t daddr;
      word_t dstore;
      logic  mod_wr;   // store hit own cache as modified, no bus traffic
   } core_req_t;

   typedef struct packed {
      logic  iwait;
      word_t iload;
      logic  dwait;
      word_t dload;
   } core_rsp_t;

   typedef struct packed {
      logic  valid;
      addr_t addr;
   } snoop_req_t;

   typedef struct packed {
      logic  ccwrite;   // modified copy held here
      addr_t wb_addr;
      word_t wb_data;
   } snoop_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } ram_req_t;

   // one modified line in a responder table
   typedef struct packed {
      addr_t addr;
      word_t data;
   } mod_line_t;

endpackage

`default_nettype wire

//--- verilog/coherent_mem_sys.sv
// coherent_mem_sys
// memory side of the dual-core system: controller, RAM model
// and one snoop responder per core
`timescale 1ns/1ps
`default_nettype none

module coherent_mem_sys (
   input  logic                                               CLK,
   input  logic                                               nRST,
   input  coherence_pkg::core_req_t [coherence_pkg::NCORES-1:0] core_req,
   output coherence_pkg::core_rsp_t [coherence_pkg::NCORES-1:0] core_rsp
);

   coherence_pkg::snoop_req_t [coherence_pkg::NCORES-1:0] snoop_req;
   coherence_pkg::snoop_rsp_t [coherence_pkg::NCORES-1:0] snoop_rsp;
   logic                      [coherence_pkg::NCORES-1:0] wb_done;
   coherence_pkg::ram_req_t                               ram_req;
   coherence_pkg::word_t                                  ram_load;
   coherence_pkg::ram_state_t                             ram_state;

   memory_control memory_control (
      .CLK       (CLK),
      .nRST      (nRST),
      .core_req  (core_req),
      .core_rsp  (core_rsp),
      .snoop_req (snoop_req),
      .snoop_rsp (snoop_rsp),
      .wb_done   (wb_done),
      .ram_req   (ram_req),
      .ram_load  (ram_load),
      .ram_state (ram_state)
   );

   ram_model ram_model (
      .CLK       (CLK),
      .nRST      (nRST),
      .ram_req   (ram_req),
      .ram_load  (ram_load),
      .ram_state (ram_state)
   );

   // core 0 dirty lines
   snoop_responder snoop_responder0 (
      .CLK       (CLK),
      .nRST      (nRST),
      .core_req  (core_req[0]),
      .snoop_req (snoop_req[0]),
      .wb_done   (wb_done[0]),
      .snoop_rsp (snoop_rsp[0])
   );

   // core 1 dirty lines
   snoop_responder snoop_responder1 (
      .CLK       (CLK),
      .nRST      (nRST),
      .core_req  (core_req[1]),
      .snoop_req (snoop_req[1]),
      .wb_done   (wb_done[1]),
      .snoop_rsp (snoop_rsp[1])
   );

endmodule

`default_nettype wire

//--- verilog/memory_control.sv
// memory_control
// shared memory controller for two cores: instruction fetches go straight to RAM,
// data accesses snoop the other core first and take a modified line cache to cache
// while writing it back; otherwise the access goes to RAM
`timescale 1ns/1ps
`default_nettype none

module memory_control (
   input  logic                                                CLK,
   input  logic                                                nRST,
   input  coherence_pkg::core_req_t  [coherence_pkg::NCORES-1:0] core_req,
   output coherence_pkg::core_rsp_t  [coherence_pkg::NCORES-1:0] core_rsp,
   output coherence_pkg::snoop_req_t [coherence_pkg::NCORES-1:0] snoop_req,
   input  coherence_pkg::snoop_rsp_t [coherence_pkg::NCORES-1:0] snoop_rsp,
   output logic                      [coherence_pkg::NCORES-1:0] wb_done,
   output coherence_pkg::ram_req_t                             ram_req,
   input  coherence_pkg::word_t                                ram_load,
   input  coherence_pkg::ram_state_t                           ram_state
);

   coherence_pkg::mc_state_t state, next_state;
   coherence_pkg::addr_t     snoop_addr;   // requester daddr held for the snoop
   logic                     c2c_sent;     // dirty word already handed over
   logic                     i_sel, i_sel_q;
   logic                     req_id, oth_id;
   logic                     ram_done;

   assign ram_done = (ram_state == coherence_pkg::ACCESS);

   // core being served and the core being snooped
   assign req_id = (state == coherence_pkg::SNOOP1) || (state == coherence_pkg::CACHE1) ||
                   (state == coherence_pkg::MEM1);
   assign oth_id = ~req_id;

   // fetch owner only changes while RAM is free, so a dropped iren
   // mid-ACCESS cannot hand the word to the other core
   assign i_sel = (ram_state == coherence_pkg::FREE) ? ~core_req[0].iren : i_sel_q;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state    <= coherence_pkg::IDLE;
         c2c_sent <= 1'b0;
         i_sel_q  <= 1'b0;
      end else begin
         state    <= next_state;
         c2c_sent <= (state == coherence_pkg::CACHE0) || (state == coherence_pkg::CACHE1);
         i_sel_q  <= i_sel;
      end
   end

   // latch address of the winning data request
   always_ff @(posedge CLK) begin
      if (state == coherence_pkg::IDLE) begin
         if (core_req[0].dren || core_req[0].dwen)
            snoop_addr <= core_req[0].daddr;
         else
            snoop_addr <= core_req[1].daddr;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         coherence_pkg::IDLE: begin
            if (core_req[0].dren || core_req[0].dwen)   // core 0 first
               next_state = coherence_pkg::SNOOP0;
            else if (core_req[1].dren || core_req[1].dwen)
               next_state = coherence_pkg::SNOOP1;
         end
         coherence_pkg::SNOOP0, coherence_pkg::SNOOP1: begin
            if (snoop_rsp[oth_id].ccwrite)
               next_state = req_id ? coherence_pkg::CACHE1 : coherence_pkg::CACHE0;
            else
               next_state = req_id ? coherence_pkg::MEM1 : coherence_pkg::MEM0;
         end
         coherence_pkg::CACHE0, coherence_pkg::CACHE1: begin
            // hold until the other core drops its line to shared
            if (!snoop_rsp[oth_id].ccwrite)
               next_state = coherence_pkg::IDLE;
         end
         coherence_pkg::MEM0, coherence_pkg::MEM1: begin
            if (ram_done)
               next_state = coherence_pkg::IDLE;
         end
         default: next_state = coherence_pkg::IDLE;
      endcase
   end

   always_comb begin
      for (int i = 0; i < coherence_pkg::NCORES; i++) begin
         core_rsp[i].iwait   = 1'b1;
         core_rsp[i].iload   = ram_load;
         core_rsp[i].dwait   = 1'b1;
         core_rsp[i].dload   = '0;
         snoop_req[i].valid  = 1'b0;
         snoop_req[i].addr   = snoop_addr;
      end
      wb_done = '0;
      ram_req = '0;

      case (state)
         coherence_pkg::IDLE: begin
            // instruction fetch only here
            ram_req.ren             = core_req[i_sel].iren;
            ram_req.addr            = core_req[i_sel].iaddr;
            core_rsp[i_sel].iwait   = ~ram_done;
         end
         coherence_pkg::SNOOP0, coherence_pkg::SNOOP1: begin
            snoop_req[oth_id].valid = 1'b1;
         end
         coherence_pkg::CACHE0, coherence_pkg::CACHE1: begin
            snoop_req[oth_id].valid = 1'b1;   // keeps ccwrite up until wb_done
            // cache to cache, word goes out in the first cycle
            core_rsp[req_id].dwait  = c2c_sent;
            core_rsp[req_id].dload  = snoop_rsp[oth_id].wb_data;
            // write-back of the same line
            ram_req.wen             = snoop_rsp[oth_id].ccwrite;
            ram_req.addr            = snoop_rsp[oth_id].wb_addr;
            ram_req.store           = snoop_rsp[oth_id].wb_data;
            wb_done[oth_id]         = ram_done;
         end
         coherence_pkg::MEM0, coherence_pkg::MEM1: begin
            ram_req.ren             = core_req[req_id].dren;
            ram_req.wen             = core_req[req_id].dwen;
            ram_req.addr            = core_req[req_id].daddr;
            ram_req.store           = core_req[req_id].dstore;
            core_rsp[req_id].dwait  = ~ram_done;
            core_rsp[req_id].dload  = ram_load;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/ram_model.sv
// ram_model
// word-addressed data memory with a fixed access latency
// reports FREE/BUSY/ACCESS and completes each access in the ACCESS cycle
`timescale 1ns/1ps
`default_nettype none

module ram_model (
   input  logic                      CLK,
   input  logic                      nRST,
   input  coherence_pkg::ram_req_t   ram_req,
   output coherence_pkg::word_t      ram_load,
   output coherence_pkg::ram_state_t ram_state
);

   coherence_pkg::word_t     mem [coherence_pkg::RAM_WORDS] = '{default: '0};
   coherence_pkg::lat_cnt_t  lat_cnt;
   coherence_pkg::word_idx_t widx;
   logic                     req_on;
   logic                     done_edge;

   assign req_on    = ram_req.ren | ram_req.wen;
   assign widx      = ram_req.addr[coherence_pkg::WORD_LSB +: coherence_pkg::WORD_BITS];
   // edge into ACCESS
   assign done_edge = (ram_state == coherence_pkg::BUSY) && req_on &&
                      (lat_cnt == coherence_pkg::lat_cnt_t'(coherence_pkg::RAM_LATENCY - 1));

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         ram_state <= coherence_pkg::FREE;
         lat_cnt   <= '0;
      end else begin
         case (ram_state)
            coherence_pkg::FREE: begin
               if (req_on) begin
                  ram_state <= coherence_pkg::BUSY;
                  lat_cnt   <= coherence_pkg::lat_cnt_t'(1);   // first cycle already counted
               end
            end
            coherence_pkg::BUSY: begin
               if (!req_on)
                  ram_state <= coherence_pkg::FREE;   // request withdrawn
               else if (done_edge)
                  ram_state <= coherence_pkg::ACCESS;
               else
                  lat_cnt <= lat_cnt + 1'b1;
            end
            default: ram_state <= coherence_pkg::FREE;   // ACCESS lasts one cycle
         endcase
      end
   end

   // write lands and read data is captured entering ACCESS
   // so both stay valid even if the requester moves on mid-cycle
   always_ff @(posedge CLK) begin
      if (done_edge && ram_req.wen)
         mem[widx] <= ram_req.store;
      if (done_edge && ram_req.ren)
         ram_load <= mem[widx];
   end

endmodule

`default_nettype wire

//--- verilog/snoop_responder.sv
// snoop_responder
// stands in for the modified-line part of one L1 data cache
// small table of dirty lines, answers snoops and drops a line to shared on write-back
`timescale 1ns/1ps
`default_nettype none

module snoop_responder (
   input  logic                      CLK,
   input  logic                      nRST,
   input  coherence_pkg::core_req_t  core_req,
   input  coherence_pkg::snoop_req_t snoop_req,
   input  logic                      wb_done,
   output coherence_pkg::snoop_rsp_t snoop_rsp
);

   logic [coherence_pkg::MOD_ENTRIES-1:0] ent_valid;
   coherence_pkg::mod_line_t              lines [coherence_pkg::MOD_ENTRIES];
   coherence_pkg::ent_idx_t               rr_ptr;     // victim when full
   coherence_pkg::word_idx_t              wr_word, snp_word;
   coherence_pkg::ent_idx_t               wr_idx, free_idx, snp_idx, mod_idx;
   logic                                  wr_hit, free_found, snp_hit;

   assign wr_word  = core_req.daddr[coherence_pkg::WORD_LSB +: coherence_pkg::WORD_BITS];
   assign snp_word = snoop_req.addr[coherence_pkg::WORD_LSB +: coherence_pkg::WORD_BITS];

   // table lookups, store side and snoop side
   always_comb begin
      wr_hit     = 1'b0;
      wr_idx     = '0;
      free_found = 1'b0;
      free_idx   = '0;
      snp_hit    = 1'b0;
      snp_idx    = '0;
      for (int i = 0; i < coherence_pkg::MOD_ENTRIES; i++) begin
         if (ent_valid[i] &&
             lines[i].addr[coherence_pkg::WORD_LSB +: coherence_pkg::WORD_BITS] == wr_word) begin
            wr_hit = 1'b1;
            wr_idx = coherence_pkg::ent_idx_t'(i);
         end
         if (!ent_valid[i] && !free_found) begin   // lowest free slot
            free_found = 1'b1;
            free_idx   = coherence_pkg::ent_idx_t'(i);
         end
         if (ent_valid[i] && !snp_hit &&
             lines[i].addr[coherence_pkg::WORD_LSB +: coherence_pkg::WORD_BITS] == snp_word) begin
            snp_hit = 1'b1;
            snp_idx = coherence_pkg::ent_idx_t'(i);
         end
      end
      if (wr_hit)
         mod_idx = wr_idx;
      else if (free_found)
         mod_idx = free_idx;
      else
         mod_idx = rr_ptr;   // full, old line is lost
   end

   // same-cycle answer to the controller
   always_comb begin
      snoop_rsp.ccwrite = snoop_req.valid & snp_hit;
      snoop_rsp.wb_addr = snoop_rsp.ccwrite ? lines[snp_idx].addr : '0;
      snoop_rsp.wb_data = snoop_rsp.ccwrite ? lines[snp_idx].data : '0;
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         ent_valid <= '0;
         rr_ptr    <= '0;
      end else begin
         if (core_req.mod_wr) begin
            ent_valid[mod_idx] <= 1'b1;
            if (!wr_hit && !free_found)
               rr_ptr <= rr_ptr + 1'b1;
         end
         if (wb_done && snp_hit)
            ent_valid[snp_idx] <= 1'b0;   // M -> S, RAM now current
      end
   end

   always_ff @(posedge CLK) begin
      if (core_req.mod_wr) begin
         lines[mod_idx].addr <= core_req.daddr;
         lines[mod_idx].data <= core_req.dstore;
      end
   end

endmodule

`default_nettype wire
